// File: design/rtcDisplayPkg.sv
package rtcDisplayPkg;

    ////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////

    typedef logic [6:0] fieldValue_t;   // Binary field value, 0 to 99

    // One field as two ASCII characters
    typedef struct packed {
        logic [6:0] tens;
        logic [6:0] units;
    } asciiPair_t;

    typedef logic [11:0] rgb_t;         // 4 bits each of red, green, blue

    // Capture sequencer states
    typedef enum logic [1:0] {
        capIdle,
        capCollect,
        capCommit
    } captureState_t;

    ////////////////////////////////////////////////////////////
    // Default parameters
    ////////////////////////////////////////////////////////////

    // 640x480 at 60 Hz, one pixel per clk
    localparam int defHActive = 640;
    localparam int defHFront  = 16;
    localparam int defHSync   = 96;
    localparam int defHBack   = 48;
    localparam int defVActive = 480;
    localparam int defVFront  = 10;
    localparam int defVSync   = 2;
    localparam int defVBack   = 33;

    localparam int defNumFields = 3;    // Seconds, minutes, hours

    // Top left corner of the HH:MM:SS line, roughly centred
    localparam int defTextX = 288;
    localparam int defTextY = 232;

    localparam rgb_t defFgColor = 12'hFFF;  // White

    localparam int glyphWidth  = 8;
    localparam int glyphHeight = 16;

    localparam logic [6:0] asciiZero  = 7'h30;  // '0'
    localparam logic [6:0] asciiColon = 7'h3A;  // ':'

    ////////////////////////////////////////////////////////////
    // Glyph ROM
    ////////////////////////////////////////////////////////////

    // 8x16 glyphs, row 0 in the top byte, MSB is the leftmost pixel
    function automatic logic [7:0] glyphRow(input logic [6:0] code, input logic [3:0] row);
        logic [127:0] glyph;
        case (code)
            7'h30:   glyph = 128'h0000_7CC6_C6CE_DEF6_E6C6_C67C_0000_0000;  // 0
            7'h31:   glyph = 128'h0000_1838_7818_1818_1818_187E_0000_0000;  // 1
            7'h32:   glyph = 128'h0000_7CC6_060C_1830_60C0_C6FE_0000_0000;  // 2
            7'h33:   glyph = 128'h0000_7CC6_0606_3C06_0606_C67C_0000_0000;  // 3
            7'h34:   glyph = 128'h0000_0C1C_3C6C_CCFE_0C0C_0C1E_0000_0000;  // 4
            7'h35:   glyph = 128'h0000_FEC0_C0C0_FC06_0606_C67C_0000_0000;  // 5
            7'h36:   glyph = 128'h0000_3860_C0C0_FCC6_C6C6_C67C_0000_0000;  // 6
            7'h37:   glyph = 128'h0000_FEC6_0606_0C18_3030_3030_0000_0000;  // 7
            7'h38:   glyph = 128'h0000_7CC6_C6C6_7CC6_C6C6_C67C_0000_0000;  // 8
            7'h39:   glyph = 128'h0000_7CC6_C6C6_7E06_0606_0C78_0000_0000;  // 9
            7'h3A:   glyph = 128'h0000_0000_1818_0000_0018_1800_0000_0000;  // Colon
            default: glyph = '0;                                           // Blank cell
        endcase
        // Row 0 sits in bits 127:120
        return glyph[8 * (15 - int'(row)) +: 8];
    endfunction

endpackage

// File: design/fieldBus.sv
`timescale 1ns/100ps

// Capture writes and commit, sequencer to digit slots
interface fieldBus #(
    parameter int numFields = rtcDisplayPkg::defNumFields
);
    localparam int idxWidth = (numFields > 1) ? $clog2(numFields) : 1;

    logic                       captureEn;   // Write strobe for one slot
    logic [idxWidth-1:0]        captureIdx;  // Slot addressed by the write
    rtcDisplayPkg::fieldValue_t fieldData;   // Binary value to convert
    logic                       commit;      // Staging to display, all slots

    // Sequencer side
    modport source (
        output captureEn, captureIdx, fieldData, commit
    );

    // Slot side
    modport sink (
        input captureEn, captureIdx, fieldData, commit
    );

endinterface

// File: design/vgaSyncGen.sv
`timescale 1ns/100ps

module vgaSyncGen #(
    parameter int hActive = rtcDisplayPkg::defHActive,
    parameter int hFront  = rtcDisplayPkg::defHFront,
    parameter int hSync   = rtcDisplayPkg::defHSync,
    parameter int hBack   = rtcDisplayPkg::defHBack,
    parameter int vActive = rtcDisplayPkg::defVActive,
    parameter int vFront  = rtcDisplayPkg::defVFront,
    parameter int vSync   = rtcDisplayPkg::defVSync,
    parameter int vBack   = rtcDisplayPkg::defVBack
) (
    input  logic       clk,
    input  logic       rstN,
    output logic [9:0] pixelX,
    output logic [9:0] pixelY,
    output logic       videoOn,
    output logic       hsyncRaw,
    output logic       vsyncRaw,
    output logic       blankStart
);

    localparam int hTotal = hActive + hFront + hSync + hBack;   // 800 cycles per line
    localparam int vTotal = vActive + vFront + vSync + vBack;   // 525 lines per frame

    // Sync pulse edges
    localparam int hSyncStart = hActive + hFront;
    localparam int hSyncEnd   = hSyncStart + hSync;
    localparam int vSyncStart = vActive + vFront;
    localparam int vSyncEnd   = vSyncStart + vSync;

    logic lineEnd;
    logic frameEnd;

    assign lineEnd  = (pixelX == 10'(hTotal - 1));
    assign frameEnd = (pixelY == 10'(vTotal - 1));

    ////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixelX <= '0;
            pixelY <= '0;
        end else if (lineEnd) begin
            pixelX <= '0;                       // Wrap at end of line
            if (frameEnd) begin
                pixelY <= '0;
            end else begin
                pixelY <= pixelY + 10'd1;
            end
        end else begin
            pixelX <= pixelX + 10'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // Both syncs active low
    assign hsyncRaw = !((pixelX >= 10'(hSyncStart)) && (pixelX < 10'(hSyncEnd)));
    assign vsyncRaw = !((pixelY >= 10'(vSyncStart)) && (pixelY < 10'(vSyncEnd)));

    assign videoOn = (pixelX < 10'(hActive)) && (pixelY < 10'(vActive));

    // First pixel of the first blanked line opens the capture window
    assign blankStart = (pixelX == 10'd0) && (pixelY == 10'(vActive));

    // Counter must wrap before the line total
    pixelXRange: assert property (@(posedge clk) disable iff (!rstN)
        pixelX < 10'(hTotal));

endmodule

// File: design/fieldCapture.sv
`timescale 1ns/100ps

module fieldCapture #(
    parameter int numFields = rtcDisplayPkg::defNumFields,
    parameter int vActive   = rtcDisplayPkg::defVActive
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       blankStart,  // Window opens here
    input  logic [9:0]                 pixelY,
    input  logic                       fieldValid,  // Plain strobe, no back-pressure
    input  rtcDisplayPkg::fieldValue_t fieldData,
    fieldBus.source                    bus
);

    localparam int idxWidth = (numFields > 1) ? $clog2(numFields) : 1;
    localparam logic [idxWidth-1:0] lastIdx = idxWidth'(numFields - 1);

    rtcDisplayPkg::captureState_t state;
    logic [idxWidth-1:0]          idx;        // Next field to be written
    logic                         inBlank;
    logic                         writeNow;

    assign inBlank  = (pixelY >= 10'(vActive));     // Drops at line 0 of the next frame
    assign writeNow = (state == rtcDisplayPkg::capCollect) && inBlank && fieldValid;

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state         <= rtcDisplayPkg::capIdle;
            idx           <= '0;
            bus.captureEn <= 1'b0;
            bus.commit    <= 1'b0;
        end else begin
            bus.captureEn <= writeNow;
            bus.commit    <= 1'b0;
            case (state)
                rtcDisplayPkg::capIdle: begin
                    if (blankStart) begin
                        state <= rtcDisplayPkg::capCollect;
                        idx   <= '0;
                    end
                end
                rtcDisplayPkg::capCollect: begin
                    if (!inBlank) begin
                        state <= rtcDisplayPkg::capIdle;    // Abort, displays keep old values
                    end else if (fieldValid) begin
                        if (idx == lastIdx) begin
                            state <= rtcDisplayPkg::capCommit;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                rtcDisplayPkg::capCommit: begin
                    bus.commit <= 1'b1;                     // One cycle after last write
                    state      <= rtcDisplayPkg::capIdle;
                end
                default: state <= rtcDisplayPkg::capIdle;
            endcase
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        if (writeNow) begin
            bus.captureIdx <= idx;
            bus.fieldData  <= fieldData;
        end
    end

    // Commit only straight after the last index was written
    commitAfterLast: assert property (@(posedge clk) disable iff (!rstN)
        bus.commit |-> $past(bus.captureEn && (bus.captureIdx == lastIdx)));

    idxInRange: assert property (@(posedge clk) disable iff (!rstN)
        bus.captureEn |-> (int'(bus.captureIdx) < numFields));

endmodule

// File: design/digitSlot.sv
`timescale 1ns/100ps

module digitSlot #(
    parameter int slotIdx = 0   // 0 seconds, 1 minutes, 2 hours
) (
    input  logic                      clk,
    input  logic                      rstN,
    fieldBus.sink                     bus,
    output rtcDisplayPkg::asciiPair_t chars     // Display register
);

    rtcDisplayPkg::asciiPair_t staging;
    rtcDisplayPkg::asciiPair_t converted;
    logic                      selected;

    assign selected = bus.captureEn && (int'(bus.captureIdx) == slotIdx);

    // Binary to ASCII, tens and units
    always_comb begin
        converted.tens  = rtcDisplayPkg::asciiZero + (bus.fieldData / 7'd10);
        converted.units = rtcDisplayPkg::asciiZero + (bus.fieldData % 7'd10);
    end

    // Staging, loaded on this slot's write
    always_ff @(posedge clk) begin
        if (selected) begin
            staging <= converted;
        end
    end

    // Display, all slots switch together on commit
    always_ff @(posedge clk) begin
        if (!rstN) begin
            chars.tens  <= rtcDisplayPkg::asciiZero;
            chars.units <= rtcDisplayPkg::asciiZero;
        end else if (bus.commit) begin
            chars <= staging;
        end
    end

    // Source must stay inside two decimal digits
    valueInRange: assert property (@(posedge clk) disable iff (!rstN)
        selected |-> (bus.fieldData <= 7'd99));

endmodule

// File: design/textRenderer.sv
`timescale 1ns/100ps

module textRenderer #(
    parameter int                  numFields = rtcDisplayPkg::defNumFields,
    parameter int                  textX     = rtcDisplayPkg::defTextX,
    parameter int                  textY     = rtcDisplayPkg::defTextY,
    parameter rtcDisplayPkg::rgb_t fgColor   = rtcDisplayPkg::defFgColor
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [9:0]                pixelX,
    input  logic [9:0]                pixelY,
    input  logic                      videoOn,
    input  logic                      hsyncRaw,
    input  logic                      vsyncRaw,
    input  rtcDisplayPkg::asciiPair_t fieldChars [numFields],
    output logic                      hsync,
    output logic                      vsync,
    output rtcDisplayPkg::rgb_t       rgb
);

    // Two digits plus a colon per field, no colon after the last
    localparam int numChars = 3 * numFields - 1;
    localparam int boxWidth = numChars * rtcDisplayPkg::glyphWidth;

    logic [9:0] boxX;
    logic [9:0] boxY;
    logic       inBox;
    logic [6:0] charCol;
    logic [6:0] groupIdx;
    logic [1:0] charPos;        // 0 tens, 1 units, 2 colon
    logic [6:0] charCode;

    ////////////////////////////////////////////////////////////
    // Stage 1, character and glyph position
    ////////////////////////////////////////////////////////////

    assign boxX  = pixelX - 10'(textX);
    assign boxY  = pixelY - 10'(textY);
    assign inBox = (pixelX >= 10'(textX)) && (pixelX < 10'(textX + boxWidth))
                && (pixelY >= 10'(textY))
                && (pixelY < 10'(textY + rtcDisplayPkg::glyphHeight));

    // Column mux, hours on the left
    always_comb begin
        charCol  = boxX[9:3];
        groupIdx = charCol / 7'd3;
        charPos  = 2'(charCol % 7'd3);
        charCode = rtcDisplayPkg::asciiColon;
        for (int f = 0; f < numFields; f++) begin
            if (int'(groupIdx) == numFields - 1 - f) begin
                if (charPos == 2'd0) begin
                    charCode = fieldChars[f].tens;
                end else if (charPos == 2'd1) begin
                    charCode = fieldChars[f].units;
                end
            end
        end
    end

    logic       inBox1;
    logic       videoOn1;
    logic       hsync1;
    logic       vsync1;
    logic [6:0] code1;
    logic [3:0] row1;
    logic [2:0] bitIdx1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            inBox1   <= 1'b0;
            videoOn1 <= 1'b0;
            hsync1   <= 1'b1;               // Syncs idle high
            vsync1   <= 1'b1;
        end else begin
            inBox1   <= inBox;
            videoOn1 <= videoOn;
            hsync1   <= hsyncRaw;
            vsync1   <= vsyncRaw;
        end
    end

    always_ff @(posedge clk) begin
        code1   <= charCode;
        row1    <= boxY[3:0];
        bitIdx1 <= 3'd7 - boxX[2:0];        // MSB is leftmost pixel
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, glyph lookup, bit select, colour
    ////////////////////////////////////////////////////////////

    logic [7:0] glyphBits;
    logic       pixelOn;

    assign glyphBits = rtcDisplayPkg::glyphRow(code1, row1);
    assign pixelOn   = glyphBits[bitIdx1] && inBox1 && videoOn1;  // Gated by video window

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= pixelOn ? fgColor : '0;
            hsync <= hsync1;                // Same latency as rgb
            vsync <= vsync1;
        end
    end

endmodule

// File: design/rtcDisplayTop.sv
`timescale 1ns/100ps

module rtcDisplayTop #(
    parameter int                  hActive   = rtcDisplayPkg::defHActive,
    parameter int                  hFront    = rtcDisplayPkg::defHFront,
    parameter int                  hSync     = rtcDisplayPkg::defHSync,
    parameter int                  hBack     = rtcDisplayPkg::defHBack,
    parameter int                  vActive   = rtcDisplayPkg::defVActive,
    parameter int                  vFront    = rtcDisplayPkg::defVFront,
    parameter int                  vSync     = rtcDisplayPkg::defVSync,
    parameter int                  vBack     = rtcDisplayPkg::defVBack,
    parameter int                  numFields = rtcDisplayPkg::defNumFields,
    parameter int                  textX     = rtcDisplayPkg::defTextX,
    parameter int                  textY     = rtcDisplayPkg::defTextY,
    parameter rtcDisplayPkg::rgb_t fgColor   = rtcDisplayPkg::defFgColor
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       fieldValid,
    input  rtcDisplayPkg::fieldValue_t fieldData,
    output logic                       hsync,
    output logic                       vsync,
    output rtcDisplayPkg::rgb_t        rgb
);

    logic [9:0] pixelX;
    logic [9:0] pixelY;
    logic       videoOn;
    logic       hsyncRaw;
    logic       vsyncRaw;
    logic       blankStart;

    rtcDisplayPkg::asciiPair_t slotChars [numFields];   // Indexed by field, 0 is seconds

    vgaSyncGen #(
        .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) syncGen (
        .clk(clk), .rstN(rstN), .pixelX(pixelX), .pixelY(pixelY), .videoOn(videoOn),
        .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw), .blankStart(blankStart)
    );

    fieldBus #(.numFields(numFields)) capBus ();

    fieldCapture #(.numFields(numFields), .vActive(vActive)) capture (
        .clk(clk), .rstN(rstN), .blankStart(blankStart), .pixelY(pixelY),
        .fieldValid(fieldValid), .fieldData(fieldData), .bus(capBus)
    );

    // One slot per clock field
    for (genvar i = 0; i < numFields; i++) begin : genSlot
        digitSlot #(.slotIdx(i)) slot (
            .clk(clk), .rstN(rstN), .bus(capBus), .chars(slotChars[i])
        );
    end

    textRenderer #(
        .numFields(numFields), .textX(textX), .textY(textY), .fgColor(fgColor)
    ) renderer (
        .clk(clk), .rstN(rstN), .pixelX(pixelX), .pixelY(pixelY), .videoOn(videoOn),
        .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw), .fieldChars(slotChars),
        .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

endmodule

// File: testbench/tbRtcModel.svh
`ifndef TB_RTC_MODEL_SVH
`define TB_RTC_MODEL_SVH

////////////////////////////////////////////////////////////
// Timing of the 640x480 frame, one pixel per clk
////////////////////////////////////////////////////////////

localparam int lineCycles    = 800;
localparam int frameCycles   = lineCycles * 525;
localparam int hSyncCycles   = 96;
localparam int vSyncCycles   = 2 * lineCycles;   // Two lines low
localparam int hSyncFallX    = 656;              // First pixel with hsync low
localparam int vSyncFallY    = 490;              // First line with vsync low
localparam int timeoutCycles = 12 * frameCycles; // About eight frames of tests plus margin

int checkCount = 0;
int errorCount = 0;

// Compare one value and report a mismatch
task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
        errorCount++;
        $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
endtask

////////////////////////////////////////////////////////////
// Expected colour of one pixel
////////////////////////////////////////////////////////////

function automatic rtcDisplayPkg::rgb_t expectedPixel(input int x, input int y,
        input int hours, input int minutes, input int seconds);
    int         boxX;
    int         boxY;
    int         col;
    int         digits[6];
    logic [6:0] code;
    logic [7:0] pattern;
    boxX = x - rtcDisplayPkg::defTextX;
    boxY = y - rtcDisplayPkg::defTextY;
    if (x >= 640 || y >= 480) begin
        return '0;                                  // Blanking is always black
    end
    if (boxX < 0 || boxX >= 64 || boxY < 0 || boxY >= 16) begin
        return '0;                                  // Outside the HH:MM:SS box
    end
    // Characters left to right, colons at columns 2 and 5
    digits = '{hours / 10, hours % 10, minutes / 10, minutes % 10,
               seconds / 10, seconds % 10};
    col = boxX / 8;
    if (col == 2 || col == 5) begin
        code = 7'h3A;
    end else begin
        code = 7'h30 + 7'(digits[col - col / 3]);   // Skip the colons before col
    end
    pattern = rtcDisplayPkg::glyphRow(code, 4'(boxY));
    return pattern[7 - boxX % 8] ? rtcDisplayPkg::defFgColor : '0;
endfunction

`endif

// File: testbench/tbRtcDisplay.sv
`timescale 1ns/100ps

module tbRtcDisplay;

    `include "tbRtcModel.svh"

    logic                       clk;
    logic                       rstN;
    logic                       fieldValid;
    rtcDisplayPkg::fieldValue_t fieldData;
    logic                       hsync;
    logic                       vsync;
    rtcDisplayPkg::rgb_t        rgb;

    integer seed       = 32'h1304_f180;
    string  testName   = "firstFrame";
    int     expHours   = 0;         // Values the screen should show
    int     expMinutes = 0;
    int     expSeconds = 0;
    int     cycleCount = 0;

    // Frame scanner state
    logic                prevH      = 1'b1;
    logic                prevV      = 1'b1;
    logic                hLocked    = 1'b0;
    logic                vLocked    = 1'b0;
    int                  scanX      = 0;
    int                  scanY      = 0;
    int                  sinceHFall = 0;
    int                  sinceVFall = 0;
    int                  hLow       = 0;
    int                  vLow       = 0;
    logic                sampReady  = 1'b0;
    int                  sampX;
    int                  sampY;
    rtcDisplayPkg::rgb_t sampRgb;

    rtcDisplayTop uut (
        .clk(clk), .rstN(rstN), .fieldValid(fieldValid), .fieldData(fieldData),
        .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // Scanner, recovers x and y from the sync edges
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rstN) begin
            sinceHFall++;
            sinceVFall++;
            if (scanX == lineCycles - 1) begin
                scanX = 0;
                scanY = (scanY == 524) ? 0 : scanY + 1;
            end else begin
                scanX++;
            end
            if (!hsync) hLow++;
            if (!vsync) vLow++;
            if (!hsync && prevH) begin
                if (hLocked) checkValue("hsyncPeriod", lineCycles, sinceHFall);
                hLocked    = 1'b1;
                scanX      = hSyncFallX;
                sinceHFall = 0;
            end
            if (hsync && !prevH) begin
                checkValue("hsyncWidth", hSyncCycles, hLow);
                hLow = 0;
            end
            if (!vsync && prevV) begin
                if (vLocked) checkValue("vsyncPeriod", frameCycles, sinceVFall);
                if (hLocked) checkValue("vsyncAlign", 0, scanX);    // Falls at pixel 0
                vLocked    = 1'b1;
                scanY      = vSyncFallY;
                sinceVFall = 0;
            end
            if (vsync && !prevV) begin
                checkValue("vsyncWidth", vSyncCycles, vLow);
                vLow = 0;
            end
            prevH     = hsync;
            prevV     = vsync;
            sampX     = scanX;
            sampY     = scanY;
            sampRgb   = rgb;
            sampReady = hLocked && vLocked;
        end
    end

    // Every pixel after lock against the model
    always @(posedge clk) begin
        if (sampReady) begin
            checkValue(testName, expectedPixel(sampX, sampY, expHours, expMinutes,
                       expSeconds), sampRgb);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic checkIdleOutputs(input string name);
        checkValue({name, " hsync"}, 1, hsync);
        checkValue({name, " vsync"}, 1, vsync);
        checkValue({name, " rgb"}, 0, rgb);
    endtask

    task automatic waitVsyncFall();
        @(negedge vsync);           // Line 490, capture window open
    endtask

    task automatic waitActiveLine();
        do begin
            @(posedge clk);
        end while (!(sampReady && sampY >= 100 && sampY < 400));
    endtask

    // Random gap, then one strobe cycle
    task automatic strobeValue(output int value);
        repeat ($unsigned($random(seed)) % 16) @(posedge clk);
        value = $unsigned($random(seed)) % 100;
        fieldValid <= 1'b1;
        fieldData  <= 7'(value);
        @(posedge clk);
        fieldValid <= 1'b0;
    endtask

    // Seconds, minutes, hours in that order
    task automatic sendFields(input int count);
        int values[3];
        for (int i = 0; i < count; i++) begin
            strobeValue(values[i]);
        end
        if (count == 3) begin       // Only a full sequence commits
            expSeconds = values[0];
            expMinutes = values[1];
            expHours   = values[2];
        end
    endtask

    task automatic strobeOutsideWindow();
        int junk;
        repeat (8) strobeValue(junk);
    endtask

    initial begin
        rstN       = 1'b0;
        fieldValid = 1'b0;
        fieldData  = '0;
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            checkIdleOutputs("resetActive");
        end
        @(posedge clk);
        rstN <= 1'b1;               // Low for 3 rising edges
        repeat (3) begin
            @(negedge clk);
            checkIdleOutputs("afterReset");
        end
        waitVsyncFall();            // First window left empty, frame shows 00:00:00
        waitVsyncFall();
        testName = "capture";
        sendFields(3);
        waitVsyncFall();
        testName = "incomplete";
        sendFields(2);              // Aborts at line 0, old values stay
        repeat (4) begin
            waitActiveLine();
            strobeOutsideWindow();
            waitVsyncFall();
            sendFields(3);
            testName = "ignoredStrobes";
        end
        waitVsyncFall();            // Last frame fully scanned
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
        $display("checks %0d, errors %0d", checkCount, errorCount);
        $display("sim failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+testbench
design/rtcDisplayPkg.sv
design/fieldBus.sv
design/vgaSyncGen.sv
design/fieldCapture.sv
design/digitSlot.sv
design/textRenderer.sv
design/rtcDisplayTop.sv
testbench/tbRtcDisplay.sv
